/* sources.f */
+incdir+include
verilog/cpu_isa_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/cpu_regfile.sv
verilog/cpu_alu.sv
verilog/cpu_datapath.sv
verilog/cpu_ctrl.sv
verilog/cpu_core.sv
tb/cpu_core_sva.sv
tb/cpu_core_tb.sv

/* tb/cpu_core_tb.sv */
/*
 * RISC5 core testbench with a random-wait memory responder
 * and a random instruction stream checked against an ISA model
 */

`timescale 1ns/10ps

`include "cpu_settings.svh"

module cpu_core_tb
  import cpu_isa_pkg::*;
();

  localparam int clk_period   = 8;
  localparam int reset_cycles = 8;
  localparam int n_instr      = 400;
  localparam int max_cycles   = 12;     // slowest instruction incl. bus waits
  localparam int timeout_ns   = (n_instr * max_cycles + reset_cycles) * clk_period;

  typedef enum {xfer_none, xfer_load, xfer_store} xfer_t;

  logic                   clk;
  logic                   rst;
  logic                   bus_stb;
  logic                   bus_we;
  logic [`CPU_ADDR_W-1:0] bus_addr;
  logic [`CPU_DATA_W-1:0] bus_din;
  logic [`CPU_DATA_W-1:0] bus_dout;
  logic                   bus_ack;

  // --------------------------------------------------
  // isa model state
  // --------------------------------------------------
  logic [`CPU_DATA_W-1:0] reg_m [0:`CPU_REG_N-1];
  logic [`CPU_ADDR_W-1:0] pc_m;
  logic                   fn, fz, fc, fv;
  logic [`CPU_DATA_W-1:0] mem_m [logic [`CPU_ADDR_W-1:0]];
  xfer_t                  pending;             // data transfer still owed
  logic [`CPU_ADDR_W-1:0] exp_addr;
  logic [`CPU_DATA_W-1:0] exp_data;

  int   insn_count;
  logic done;
  int   fetch_errors, load_errors, store_errors, other_errors;

  cpu_core u_cpu_core (.*);

  initial begin : clock_gen
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_addr(input logic [`CPU_ADDR_W-1:0] got,
                            input logic [`CPU_ADDR_W-1:0] want);
    if (got !== want) begin
      fetch_errors++;
      $display("Fail %0t: fetch address %h, expected %h", $time, got, want);
    end
  endtask

  task automatic check_load_addr(input logic [`CPU_ADDR_W-1:0] got,
                                 input logic [`CPU_ADDR_W-1:0] want);
    if (got !== want) begin
      load_errors++;
      $display("Fail %0t: load address %h, expected %h", $time, got, want);
    end
  endtask

  task automatic check_store(input logic [`CPU_ADDR_W-1:0] got_addr,
                             input logic [`CPU_ADDR_W-1:0] want_addr,
                             input logic [`CPU_DATA_W-1:0] got_data,
                             input logic [`CPU_DATA_W-1:0] want_data);
    if (got_addr !== want_addr || got_data !== want_data) begin
      store_errors++;
      $display("Fail %0t: store %h to %h, expected %h to %h", $time,
               got_data, got_addr, want_data, want_addr);
    end
  endtask

  task automatic verify_direction(input logic got, input logic want, input string what);
    if (got !== want) begin
      other_errors++;
      $display("Fail %0t: bus_we %b during a %s, expected %b", $time, got, what, want);
    end
  endtask

  // --------------------------------------------------
  // isa model
  // --------------------------------------------------
  task automatic alu_model(input alu_op_t f, input logic [31:0] x, input logic [31:0] y,
                           input logic cin, output logic [31:0] r,
                           output logic co, output logic vo);
    logic [32:0] wide;
    logic [4:0]  sh;
    sh = y[4:0];
    co = 1'b0;
    vo = 1'b0;
    case (f)
      op_mov: r = y;
      op_lsl: r = x << sh;
      op_asr: r = $signed(x) >>> sh;
      op_ror: r = (x >> sh) | (x << (6'd32 - sh));
      op_and: r = x & y;
      op_ann: r = x & ~y;
      op_ior: r = x | y;
      op_xor: r = x ^ y;
      op_add: begin
        wide = {1'b0, x} + {1'b0, y} + cin;
        r    = wide[31:0];
        co   = wide[32];                            // carry out
        vo   = (x[31] == y[31]) && (r[31] != x[31]);
      end
      op_sub: begin
        wide = {1'b0, x} - {1'b0, y} - cin;
        r    = wide[31:0];
        co   = wide[32];                            // borrow
        vo   = (x[31] != y[31]) && (r[31] != x[31]);
      end
      default: r = '0;
    endcase
  endtask

  function automatic logic cond_taken(input logic [3:0] a);
    logic t;
    case (cond_t'(a[2:0]))
      cond_mi: t = fn;
      cond_eq: t = fz;
      cond_cs: t = fc;
      cond_vs: t = fv;
      cond_ls: t = fc | fz;
      cond_lt: t = fn ^ fv;
      cond_le: t = (fn ^ fv) | fz;
      default: t = 1'b1;
    endcase
    return a[3] ^ t;                                // a[3] negates
  endfunction

  task automatic step_model(input logic [`CPU_DATA_W-1:0] insn);
    fmt_t                   f;
    logic                   u, v, co, vo;
    reg_idx_t               a, b, c;
    logic [3:0]             opc;
    logic [`CPU_DATA_W-1:0] x, y, r, link;
    logic [`CPU_ADDR_W-1:0] target;
    f    = fmt_t'(insn[31:30]);
    u    = insn[29];
    v    = insn[28];
    a    = insn[27:24];
    b    = insn[23:20];
    opc  = insn[19:16];
    c    = insn[3:0];
    link = {{(`CPU_DATA_W-`CPU_ADDR_W){1'b0}}, pc_m} + `CPU_PC_INC;
    pc_m = link[`CPU_ADDR_W-1:0];
    case (f)
      fmt_mem: begin
        x        = reg_m[b] + {{12{insn[19]}}, insn[19:0]};
        exp_addr = x[`CPU_ADDR_W-1:0];
        if (u) begin
          exp_data        = reg_m[a];
          mem_m[exp_addr] = exp_data;
          pending         = xfer_store;
        end else begin
          if (!mem_m.exists(exp_addr)) begin
            mem_m[exp_addr] = $urandom;             // unwritten word
          end
          exp_data = mem_m[exp_addr];
          reg_m[a] = exp_data;
          fn       = exp_data[31];
          fz       = (exp_data == 0);
          pending  = xfer_load;
        end
      end
      fmt_branch: begin
        if (u) begin
          target = link[`CPU_ADDR_W-1:0] + {insn[21:0], 2'b00};
        end else begin
          target = reg_m[c][`CPU_ADDR_W-1:0];
        end
        if ((u || v || insn[7:4] == 4'h0) && cond_taken(a)) begin
          if (v) begin
            reg_m[`CPU_LINK_REG] = link;            // call
          end
          pc_m = target;
        end
      end
      default: begin
        if (opc <= 4'd9 && !(f == fmt_reg_reg && opc == 4'd0 && u)) begin
          x = reg_m[b];
          if (f == fmt_reg_reg) begin
            y = reg_m[c];
          end else if (opc == 4'd0 && u) begin
            y = {insn[15:0], 16'h0000};
          end else begin
            y = {{16{v}}, insn[15:0]};
          end
          alu_model(alu_op_t'(opc), x, y, u & fc, r, co, vo);
          reg_m[a] = r;
          fn       = r[31];
          fz       = (r == 0);
          if (alu_op_t'(opc) == op_add || alu_op_t'(opc) == op_sub) begin
            fc = co;
            fv = vo;
          end
        end
      end
    endcase
  endtask

  // --------------------------------------------------
  // instruction generator and bus responder
  // --------------------------------------------------
  function automatic logic [3:0] rand_op();
    logic [3:0] o;
    if ($urandom_range(11, 0) == 0) begin
      o = 4'($urandom_range(15, 10));               // mul, div, float
    end else begin
      o = 4'($urandom_range(9, 0));
    end
    return o;
  endfunction

  function automatic logic [`CPU_DATA_W-1:0] gen_insn(input int idx);
    logic [`CPU_DATA_W-1:0] w;
    int                     kind;
    w    = $urandom;
    kind = $urandom_range(99, 0);
    if (idx < `CPU_REG_N) begin
      w[31:29] = 3'b010;                            // one mov imm per register
      w[27:24] = idx[3:0];
      w[19:16] = op_mov;
    end else if (kind < 30) begin
      w[31:30] = fmt_reg_reg;
      w[19:16] = rand_op();
    end else if (kind < 55) begin
      w[31:30] = fmt_reg_imm;
      w[19:16] = rand_op();
    end else if (kind < 70) begin
      w[31:28] = 4'b1000;                           // load
    end else if (kind < 85) begin
      w[31:28] = 4'b1010;                           // store
    end else begin
      w[31:30] = fmt_branch;
      if ($urandom_range(3, 0) != 0) begin
        w[7:4] = 4'h0;
      end
    end
    return w;
  endfunction

  task automatic reply(input logic [`CPU_DATA_W-1:0] data);
    repeat ($urandom_range(3, 0)) @(negedge clk);
    bus_din = data;
    bus_ack = 1'b1;
  endtask

  initial begin : bus_responder
    logic [`CPU_ADDR_W-1:0] req_addr;
    logic [`CPU_DATA_W-1:0] req_data;
    logic [`CPU_DATA_W-1:0] insn;
    logic                   req_we;
    bus_ack = 1'b0;
    bus_din = '0;
    void'($urandom(62));
    forever begin
      @(negedge clk);
      bus_ack = 1'b0;
      if (!rst && bus_stb && !done) begin
        req_addr = bus_addr;
        req_we   = bus_we;
        req_data = bus_dout;
        case (pending)
          xfer_load: begin
            verify_direction(req_we, 1'b0, "load");
            check_load_addr(req_addr, exp_addr);
            pending = xfer_none;
            reply(exp_data);
          end
          xfer_store: begin
            verify_direction(req_we, 1'b1, "store");
            check_store(req_addr, exp_addr, req_data, exp_data);
            pending = xfer_none;
            reply(exp_data);
          end
          default: begin
            verify_direction(req_we, 1'b0, "fetch");
            check_addr(req_addr, pc_m);
            if (insn_count == n_instr) begin
              done = 1'b1;                          // last fetch left waiting
            end else begin
              insn = gen_insn(insn_count);
              step_model(insn);
              insn_count++;
              reply(insn);
            end
          end
        endcase
      end
    end
  end

  // --------------------------------------------------
  // reset, end of run and watchdog
  // --------------------------------------------------
  initial begin : run_control
    rst          = 1'b1;
    pc_m         = `CPU_RESET_PC;
    fn           = 1'b0;
    fz           = 1'b0;
    fc           = 1'b0;
    fv           = 1'b0;
    pending      = xfer_none;
    insn_count   = 0;
    done         = 1'b0;
    fetch_errors = 0;
    load_errors  = 0;
    store_errors = 0;
    other_errors = 0;
    repeat (reset_cycles) begin
      @(negedge clk);
      if (bus_stb) begin
        other_errors++;
        $display("%0t: bus_stb went high while reset was asserted", $time);
      end
    end
    rst = 1'b0;
    wait (done);
    @(negedge clk);
    other_errors += u_cpu_core.u_bus_sva.fail_count;   // bus protocol checker
    $display("fetch errors %0d, load errors %0d, store errors %0d, other errors %0d",
             fetch_errors, load_errors, store_errors, other_errors);
    if (fetch_errors + load_errors + store_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("Timeout: the core did not finish %0d instructions in time", n_instr);
    $display("Errors found");
    $finish;
  end

endmodule

/* tb/cpu_core_sva.sv */
/*
 * Bus protocol assertions for the RISC5 core top level
 */

`timescale 1ns/10ps

`include "cpu_settings.svh"

module cpu_core_sva (
  input logic                   clk,
  input logic                   rst,
  input logic                   bus_stb,
  input logic                   bus_we,
  input logic [`CPU_ADDR_W-1:0] bus_addr,
  input logic [`CPU_DATA_W-1:0] bus_dout,
  input logic                   bus_ack
);

  int fail_count = 0;    // read by the testbench at the end

  // request held until the ack edge
  hold_request: assert property (@(posedge clk) disable iff (rst)
    bus_stb && !bus_ack |=> bus_stb && $stable(bus_addr) && $stable(bus_we))
    else begin
      $error("bus request changed before acknowledge");
      fail_count++;
    end

  // write data held as well
  hold_store_data: assert property (@(posedge clk) disable iff (rst)
    bus_stb && bus_we && !bus_ack |=> $stable(bus_dout))
    else begin
      $error("store data changed before acknowledge");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk) rst |-> !bus_stb)
    else begin
      $error("bus strobe active during reset");
      fail_count++;
    end

  write_needs_strobe: assert property (@(posedge clk) bus_we |-> bus_stb)
    else begin
      $error("bus write enable without strobe");
      fail_count++;
    end

endmodule

bind cpu_core cpu_core_sva u_bus_sva (.*);

/* verilog/cpu_core.sv */
/*
 * RISC5 core top level, controller plus datapath
 */

`timescale 1ns/10ps

`include "cpu_settings.svh"

module cpu_core
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  output logic                   bus_stb,
  output logic                   bus_we,
  output logic [`CPU_ADDR_W-1:0] bus_addr,
  input  logic [`CPU_DATA_W-1:0] bus_din,
  output logic [`CPU_DATA_W-1:0] bus_dout,
  input  logic                   bus_ack
);

  // control lines into the datapath
  pc_src_t  pc_src;
  logic     pc_we;
  logic     addr_data;       // bus address from alu result
  logic     ir_we;
  a2_src_t  a2_src;
  wb_src_t  wb_src;
  logic     reg_we;
  logic     set_nz;
  logic     set_cv;
  logic     op1_reg;
  op2_src_t op2_src;
  alu_op_t  alu_fnc;

  // decoded fields back to the controller
  fmt_t       fmt;
  logic       ir_u;
  logic       ir_v;
  alu_op_t    op;
  logic [3:0] ctrl_code;
  logic       branch;

  cpu_ctrl u_ctrl (.*);

  cpu_datapath u_datapath (.*);

endmodule

/* verilog/cpu_ctrl.sv */
/*
 * RISC5 instruction sequencer: fetch, decode, execute, write-back
 */

`timescale 1ns/10ps

module cpu_ctrl
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fmt_t       fmt,
  input  logic       ir_u,
  input  logic       ir_v,
  input  alu_op_t    op,
  input  logic [3:0] ctrl_code,
  input  logic       bus_ack,
  input  logic       branch,
  output pc_src_t    pc_src,
  output logic       pc_we,
  output logic       addr_data,
  output logic       ir_we,
  output a2_src_t    a2_src,
  output wb_src_t    wb_src,
  output logic       reg_we,
  output logic       set_nz,
  output logic       set_cv,
  output logic       op1_reg,
  output op2_src_t   op2_src,
  output alu_op_t    alu_fnc,
  output logic       bus_stb,
  output logic       bus_we
);

  ctrl_state_t state, next_state;
  logic op_bad;          // mul, div and float codes
  logic imm_hi;          // format 1 mov with u

  assign op_bad = (op > op_sub);
  assign imm_hi = (op == op_mov) & ir_u;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_reset;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = st_fetch;
    pc_src     = pc_reset;
    pc_we      = 1'b0;
    addr_data  = 1'b0;
    ir_we      = 1'b0;
    a2_src     = a2_c;
    wb_src     = wb_alu;
    reg_we     = 1'b0;
    set_nz     = 1'b0;
    set_cv     = 1'b0;
    op1_reg    = 1'b0;
    op2_src    = op2_inc;
    alu_fnc    = op_mov;
    bus_stb    = 1'b0;
    bus_we     = 1'b0;
    case (state)
      st_reset: begin
        pc_we = 1'b1;                              // load reset vector
      end
      st_fetch: begin
        next_state = bus_ack ? st_decode : st_fetch;
        bus_stb    = 1'b1;
        ir_we      = bus_ack;
      end
      st_decode: begin
        pc_src  = pc_alu;                          // pc + 4
        pc_we   = 1'b1;
        alu_fnc = op_add;
        case (fmt)
          fmt_reg_reg: next_state = (op_bad | imm_hi) ? st_fetch : st_exec;
          fmt_reg_imm: next_state = op_bad ? st_fetch : st_exec;
          fmt_mem:     next_state = st_addr;
          fmt_branch: begin
            if (ir_u) begin
              next_state = st_br_rel;
            end else if (ir_v || ctrl_code == 4'h0) begin
              next_state = st_br_reg;
            end else begin
              next_state = st_fetch;               // undefined ctrl code
            end
          end
        endcase
      end
      st_exec: begin
        next_state = st_write;
        op1_reg    = 1'b1;
        alu_fnc    = op;
        if (fmt == fmt_reg_reg) begin
          op2_src = op2_reg;
        end else begin
          op2_src = imm_hi ? op2_imm_hi : op2_imm;
        end
      end
      st_write: begin
        a2_src = a2_a;
        reg_we = 1'b1;
        set_nz = 1'b1;
        set_cv = (op == op_add) | (op == op_sub);
      end
      st_addr, st_load, st_store: begin
        // address is recomputed each cycle so alu out stays put
        op1_reg = 1'b1;
        op2_src = op2_off;
        alu_fnc = op_add;
        a2_src  = a2_a;
        if (state == st_addr) begin
          next_state = ir_u ? st_store : st_load;
        end else begin
          addr_data = 1'b1;
          bus_stb   = 1'b1;
          bus_we    = (state == st_store);
          if (!bus_ack) begin
            next_state = state;
          end else if (state == st_load) begin
            next_state = st_load_wb;
          end
        end
      end
      st_load_wb: begin
        a2_src = a2_a;
        wb_src = wb_dr;
        reg_we = 1'b1;
        set_nz = 1'b1;
      end
      st_br_reg, st_br_rel: begin
        pc_src = pc_alu;
        pc_we  = branch;
        a2_src = a2_link;                          // alu out still holds pc + 4
        reg_we = ir_v & branch;
        if (state == st_br_reg) begin
          op2_src = op2_reg;
        end else begin
          op2_src = op2_dist;
          alu_fnc = op_add;
        end
      end
      default: begin
        next_state = st_reset;
      end
    endcase
  end

endmodule

/* verilog/cpu_datapath.sv */
/*
 * RISC5 datapath: pc, instruction and data registers, flags,
 * operand muxes, branch condition and bus address
 */

`timescale 1ns/10ps

`include "cpu_settings.svh"

module cpu_datapath
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`CPU_DATA_W-1:0] bus_din,
  input  pc_src_t                pc_src,
  input  logic                   pc_we,
  input  logic                   addr_data,
  input  logic                   ir_we,
  input  a2_src_t                a2_src,
  input  wb_src_t                wb_src,
  input  logic                   reg_we,
  input  logic                   set_nz,
  input  logic                   set_cv,
  input  logic                   op1_reg,
  input  op2_src_t               op2_src,
  input  alu_op_t                alu_fnc,
  output logic [`CPU_ADDR_W-1:0] bus_addr,
  output logic [`CPU_DATA_W-1:0] bus_dout,
  output fmt_t                   fmt,
  output logic                   ir_u,
  output logic                   ir_v,
  output alu_op_t                op,
  output logic [3:0]             ctrl_code,
  output logic                   branch
);

  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_DATA_W-1:0] ir;
  logic [`CPU_DATA_W-1:0] dr;                 // load data
  logic flag_n, flag_z, flag_c, flag_v;
  reg_idx_t ir_a, ir_b, ir_c, reg_a2;
  logic [15:0] ir_imm;
  logic [19:0] ir_off;
  logic [21:0] ir_dist;
  logic [`CPU_DATA_W-1:0] reg_do1, reg_do2, reg_di;
  logic [`CPU_DATA_W-1:0] alu_op1, alu_op2, alu_res, alu_out;
  logic alu_c, alu_v, use_carry, cond;

  // --------------------------------------------------
  // registers and instruction fields
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `CPU_RESET_PC;
    end else if (pc_we) begin
      pc <= (pc_src == pc_alu) ? alu_res[`CPU_ADDR_W-1:0] : `CPU_RESET_PC;
    end
    if (ir_we) begin
      ir <= bus_din;
    end
    dr <= bus_din;                            // sampled every cycle
  end

  assign fmt       = fmt_t'(ir[31:30]);
  assign ir_u      = ir[29];
  assign ir_v      = ir[28];
  assign ir_a      = ir[27:24];
  assign ir_b      = ir[23:20];
  assign op        = alu_op_t'(ir[19:16]);
  assign ir_imm    = ir[15:0];
  assign ir_off    = ir[19:0];
  assign ir_dist   = ir[21:0];
  assign ctrl_code = ir[7:4];
  assign ir_c      = ir[3:0];

  // --------------------------------------------------
  // register file and flags
  // --------------------------------------------------
  always_comb begin
    case (a2_src)
      a2_a:    reg_a2 = ir_a;                 // dst, store source
      a2_link: reg_a2 = reg_idx_t'(`CPU_LINK_REG);
      default: reg_a2 = ir_c;
    endcase
  end
  assign reg_di = (wb_src == wb_dr) ? dr : alu_out;

  cpu_regfile u_regfile (
    .clk   (clk),
    .rd_a1 (ir_b),
    .rd_a2 (reg_a2),
    .do1   (reg_do1),
    .do2   (reg_do2),
    .we    (reg_we),
    .di    (reg_di)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      flag_n <= 1'b0;
      flag_z <= 1'b0;
      flag_c <= 1'b0;
      flag_v <= 1'b0;
    end else begin
      if (set_nz) begin
        flag_n <= reg_di[`CPU_DATA_W-1];
        flag_z <= ~|reg_di;
      end
      if (set_cv) begin
        flag_c <= alu_c;
        flag_v <= alu_v;
      end
    end
  end

  // --------------------------------------------------
  // alu operands
  // --------------------------------------------------
  assign alu_op1 = op1_reg ? reg_do1 : {{(`CPU_DATA_W-`CPU_ADDR_W){1'b0}}, pc};

  always_comb begin
    case (op2_src)
      op2_reg:    alu_op2 = reg_do2;
      op2_imm:    alu_op2 = {{(`CPU_DATA_W-16){ir_v}}, ir_imm};
      op2_imm_hi: alu_op2 = {ir_imm, 16'h0000};
      op2_off:    alu_op2 = {{(`CPU_DATA_W-20){ir_off[19]}}, ir_off};
      op2_dist:   alu_op2 = {{(`CPU_DATA_W-24){ir_dist[21]}}, ir_dist, 2'b00};
      default:    alu_op2 = `CPU_PC_INC;      // next instruction
    endcase
  end

  // carry-in only for arithmetic formats with u set
  assign use_carry = ir_u & op1_reg & ((fmt == fmt_reg_reg) | (fmt == fmt_reg_imm));

  cpu_alu u_alu (
    .clk       (clk),
    .op1       (alu_op1),
    .op2       (alu_op2),
    .cin       (flag_c),
    .use_carry (use_carry),
    .fnc       (alu_fnc),
    .res       (alu_res),
    .out       (alu_out),
    .out_c     (alu_c),
    .out_v     (alu_v)
  );

  // --------------------------------------------------
  // branch condition and bus
  // --------------------------------------------------
  always_comb begin
    case (cond_t'(ir_a[2:0]))
      cond_mi:     cond = flag_n;
      cond_eq:     cond = flag_z;
      cond_cs:     cond = flag_c;
      cond_vs:     cond = flag_v;
      cond_ls:     cond = flag_c | flag_z;
      cond_lt:     cond = flag_n ^ flag_v;
      cond_le:     cond = (flag_n ^ flag_v) | flag_z;
      cond_always: cond = 1'b1;
    endcase
  end
  assign branch = ir_a[3] ^ cond;

  assign bus_addr = addr_data ? alu_out[`CPU_ADDR_W-1:0] : pc;
  assign bus_dout = reg_do2;                  // store data from r[a]

endmodule

/* verilog/cpu_alu.sv */
/*
 * RISC5 ALU: shifts, logic and add/sub with a registered result copy
 */

`timescale 1ns/10ps

`include "cpu_settings.svh"

module cpu_alu
  import cpu_isa_pkg::*;
(
  input  logic                   clk,
  input  logic [`CPU_DATA_W-1:0] op1,
  input  logic [`CPU_DATA_W-1:0] op2,
  input  logic                   cin,
  input  logic                   use_carry,
  input  alu_op_t                fnc,
  output logic [`CPU_DATA_W-1:0] res,     // same cycle, pc and address
  output logic [`CPU_DATA_W-1:0] out,     // one cycle later
  output logic                   out_c,
  output logic                   out_v
);

  logic [4:0] shamt;
  logic [`CPU_DATA_W-1:0] op3;
  logic [2*`CPU_DATA_W-1:0] ror_wide;
  logic x, y, z, res_c, res_v;

  assign shamt    = op2[4:0];
  assign op3      = {{(`CPU_DATA_W-1){1'b0}}, use_carry & cin};
  assign ror_wide = {op1, op1} >> shamt;

  always_comb begin
    case (fnc)
      op_mov:  res = op2;
      op_lsl:  res = op1 << shamt;
      op_asr:  res = $signed(op1) >>> shamt;
      op_ror:  res = ror_wide[`CPU_DATA_W-1:0];
      op_and:  res = op1 & op2;
      op_ann:  res = op1 & ~op2;
      op_ior:  res = op1 | op2;
      op_xor:  res = op1 ^ op2;
      op_add:  res = op1 + op2 + op3;
      op_sub:  res = op1 - op2 - op3;
      default: res = '0;
    endcase
  end

  // carry and overflow from the sign bits
  assign x = op1[`CPU_DATA_W-1];
  assign y = op2[`CPU_DATA_W-1];
  assign z = res[`CPU_DATA_W-1];

  always_comb begin
    res_c = 1'b0;
    res_v = 1'b0;
    if (fnc == op_add) begin
      res_c = (x & y) | (x & ~z) | (y & ~z);
      res_v = (~x & ~y & z) | (x & y & ~z);
    end else if (fnc == op_sub) begin
      res_c = (~x & y) | (~x & z) | (y & z);   // borrow
      res_v = (~x & y & z) | (x & ~y & ~z);
    end
  end

  always_ff @(posedge clk) begin
    out   <= res;
    out_c <= res_c;
    out_v <= res_v;
  end

endmodule

/* verilog/cpu_regfile.sv */
/*
 * 16 x 32 register file, two registered reads, write through port 2
 */

`timescale 1ns/10ps

`include "cpu_settings.svh"

module cpu_regfile
  import cpu_isa_pkg::*;
(
  input  logic                   clk,
  input  reg_idx_t               rd_a1,
  input  reg_idx_t               rd_a2,    // also the write address
  output logic [`CPU_DATA_W-1:0] do1,
  output logic [`CPU_DATA_W-1:0] do2,
  input  logic                   we,
  input  logic [`CPU_DATA_W-1:0] di
);

  logic [`CPU_DATA_W-1:0] regs [0:`CPU_REG_N-1];

  always_ff @(posedge clk) begin
    do1 <= regs[rd_a1];
    do2 <= regs[rd_a2];
    if (we) begin
      regs[rd_a2] <= di;
    end
  end

endmodule

/* verilog/cpu_ctrl_pkg.sv */
/*
 * RISC5 controller types: states and datapath selectors
 */

package cpu_ctrl_pkg;

  typedef enum logic [3:0] {
    st_reset, st_fetch, st_decode, st_exec, st_write,
    st_addr, st_load, st_load_wb, st_store,
    st_br_reg, st_br_rel
  } ctrl_state_t;

  typedef enum logic {pc_reset, pc_alu} pc_src_t;

  typedef enum logic [2:0] {
    op2_inc, op2_reg, op2_imm, op2_imm_hi, op2_off, op2_dist
  } op2_src_t;

  typedef enum logic [1:0] {a2_c, a2_a, a2_link} a2_src_t;

  typedef enum logic {wb_alu, wb_dr} wb_src_t;

endpackage

/* verilog/cpu_isa_pkg.sv */
/*
 * RISC5 instruction set types: formats, ALU functions, branch conditions
 */

package cpu_isa_pkg;

  typedef enum logic [1:0] {
    fmt_reg_reg,   // format 0
    fmt_reg_imm,   // format 1
    fmt_mem,       // format 2
    fmt_branch     // format 3
  } fmt_t;

  // op field values 10 to 15 have no entry, they are skipped
  typedef enum logic [3:0] {
    op_mov, op_lsl, op_asr, op_ror,
    op_and, op_ann, op_ior, op_xor,
    op_add, op_sub
  } alu_op_t;

  // a-field bits 2:0, bit 3 inverts
  typedef enum logic [2:0] {
    cond_mi, cond_eq, cond_cs, cond_vs,
    cond_ls, cond_lt, cond_le, cond_always
  } cond_t;

  typedef logic [3:0] reg_idx_t;

endpackage

/* include/cpu_settings.svh */
/*
 * RISC5 core settings: widths, reset vector and pc step
 */

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// --------------------------------------------------
// widths
// --------------------------------------------------
`define CPU_ADDR_W 24                // bus and pc address
`define CPU_DATA_W 32                // data and register word
`define CPU_REG_N  16                // general registers

// --------------------------------------------------
// fixed values
// --------------------------------------------------
`define CPU_RESET_PC 24'hFFE000      // first fetch address
`define CPU_LINK_REG 15              // calls link here
`define CPU_PC_INC   4               // bytes per instruction

`endif
